/* quant_block_top.f */
source/quant_pkg.sv
source/quant_cfg_pkg.sv
source/quant_matrix_if.sv
source/quant_matrix_regs.sv
source/coeff_quantizer.sv
source/zigzag_scan.sv
source/quant_block_top.sv
verification/quant_block_props.sv
verification/tb_quant_block.sv

/* Makefile */
TOP  := tb_quant_block
SRCS := $(shell grep -v '^+' quant_block_top.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

obj_dir/V$(TOP): quant_block_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f quant_block_top.f

clean:
	rm -rf obj_dir

/* verification/tb_quant_block.sv */
`timescale 1ns/100ps

module tb_quant_block;
    import quant_pkg::*;
    import quant_cfg_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_RANDOM = 24;
    // Directed and random blocks with some margin
    localparam int NUM_BLOCKS     = NUM_RANDOM + NUM_COEFF + 8;
    localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 10 + 200;

    typedef logic [NUM_COEFF*COEFF_W-1:0] flat_t;

    logic                  clk;
    logic                  rst_n;
    logic                  start_i;
    flat_t                 coeff_i;
    logic                  cfg_we_i;
    logic [CFG_SEL_W-1:0]  cfg_sel_i;
    logic [CFG_IDX_W-1:0]  cfg_idx_i;
    logic [CFG_DATA_W-1:0] cfg_wdata_i;
    flat_t                 level_o;
    flat_t                 recon_o;
    logic [SCAN_LEN_W-1:0] last_nz_o;
    logic                  done_o;

    // Shadow of the matrix registers
    longint m_q       [NUM_COEFF];
    longint m_iq      [NUM_COEFF];
    longint m_sharpen [NUM_COEFF];
    longint m_bias    [NUM_COEFF];
    longint m_zthresh [NUM_COEFF];

    integer seed;

    // Expected results of blocks in flight
    flat_t                 exp_lvl_q  [$];
    flat_t                 exp_rec_q  [$];
    logic [SCAN_LEN_W-1:0] exp_last_q [$];

    quant_block_top quant_block_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .coeff_i     (coeff_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_idx_i   (cfg_idx_i),
        .cfg_wdata_i (cfg_wdata_i),
        .level_o     (level_o),
        .recon_o     (recon_o),
        .last_nz_o   (last_nz_o),
        .done_o      (done_o)
    );

    bind quant_block_top quant_block_props quant_block_props_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .cfg_we_i  (cfg_we_i),
        .cfg_sel_i (cfg_sel_i),
        .level_o   (level_o),
        .last_nz_o (last_nz_o),
        .done_o    (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("The run timed out before all tests had finished");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic int scan_pos(input int raster);
        int pos;
        pos = 0;
        for (int k = 0; k < NUM_COEFF; k++) begin
            if (ZIGZAG[k] == raster) begin
                pos = k;
            end
        end
        return pos;
    endfunction

    function automatic void model_block(input flat_t coeff, output flat_t lvl_scan,
                                        output flat_t rec, output logic [SCAN_LEN_W-1:0] last);
        longint c;
        longint mag;
        longint sh;
        longint sc;
        longint lv;
        longint pr;
        flat_t  lvl_raster;
        lvl_raster = '0;
        rec        = '0;
        last       = '0;
        for (int i = 0; i < NUM_COEFF; i++) begin
            c   = longint'($signed(coeff[i*COEFF_W +: COEFF_W]));
            mag = (c < 0) ? -c : c;
            sh  = mag + m_sharpen[i];
            sc  = sh * m_iq[i] + m_bias[i];
            lv  = sc >>> QFIX;
            if (lv > MAX_LEVEL) begin
                lv = MAX_LEVEL;
            end
            if (sh <= m_zthresh[i]) begin
                lv = 0;
            end else if (c < 0) begin
                lv = -lv;
            end
            pr = lv * m_q[i];
            lvl_raster[i*COEFF_W +: COEFF_W] = COEFF_W'(lv);
            rec[i*COEFF_W +: COEFF_W]        = COEFF_W'(pr);
        end
        for (int k = 0; k < NUM_COEFF; k++) begin
            lvl_scan[k*COEFF_W +: COEFF_W] = lvl_raster[ZIGZAG[k]*COEFF_W +: COEFF_W];
            if (lvl_raster[ZIGZAG[k]*COEFF_W +: COEFF_W] != '0) begin
                last = SCAN_LEN_W'(k + 1);
            end
        end
    endfunction

    function automatic void shadow_write(input logic [CFG_SEL_W-1:0] sel, input int idx,
                                         input logic [CFG_DATA_W-1:0] data);
        case (sel)
            FIELD_Q:       m_q[idx]       = longint'(data[STEP_W-1:0]);
            FIELD_IQ:      m_iq[idx]      = longint'(data[STEP_W-1:0]);
            FIELD_BIAS:    m_bias[idx]    = longint'(data[BIAS_W-1:0]);
            FIELD_ZTHRESH: m_zthresh[idx] = longint'(data[BIAS_W-1:0]);
            FIELD_SHARPEN: m_sharpen[idx] = longint'(data[STEP_W-1:0]);
            default: ;
        endcase
    endfunction

    // --------------------------------------------------
    // Drive and check helpers
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input longint expected, input longint actual, input string what);
        if (expected !== actual) begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_outputs(input flat_t e_lvl, input flat_t e_rec,
                                 input logic [SCAN_LEN_W-1:0] e_last, input string what);
        for (int i = 0; i < NUM_COEFF; i++) begin
            check_value(longint'($signed(e_lvl[i*COEFF_W +: COEFF_W])),
                        longint'($signed(level_o[i*COEFF_W +: COEFF_W])),
                        $sformatf("%s level_o[%0d]", what, i));
            check_value(longint'($signed(e_rec[i*COEFF_W +: COEFF_W])),
                        longint'($signed(recon_o[i*COEFF_W +: COEFF_W])),
                        $sformatf("%s recon_o[%0d]", what, i));
        end
        check_value(longint'(e_last), longint'(last_nz_o), {what, " last_nz_o"});
    endtask

    task automatic write_matrix(input logic [CFG_SEL_W-1:0] sel, input int idx,
                                input logic [CFG_DATA_W-1:0] data);
        cfg_we_i    = 1'b1;
        cfg_sel_i   = sel;
        cfg_idx_i   = CFG_IDX_W'(idx);
        cfg_wdata_i = data;
        shadow_write(sel, idx, data);
        next_cycle();
        cfg_we_i = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done_o && n < 8) begin
            next_cycle();
            n++;
        end
        if (!done_o) begin
            $display("done_o never rose after start_i was pulsed");
            $display("Test FAILED");
            $fatal(1, "missing done");
        end
    endtask

    task automatic run_block(input flat_t coeff, input string what);
        flat_t                 e_lvl;
        flat_t                 e_rec;
        logic [SCAN_LEN_W-1:0] e_last;
        model_block(coeff, e_lvl, e_rec, e_last);
        coeff_i = coeff;
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        wait_done();
        check_outputs(e_lvl, e_rec, e_last, what);
    endtask

    task automatic collect_result();
        if (done_o) begin
            if (exp_lvl_q.size() == 0) begin
                $display("done_o rose with no block in flight");
                $display("Test FAILED");
                $fatal(1, "unexpected done");
            end
            check_outputs(exp_lvl_q.pop_front(), exp_rec_q.pop_front(),
                          exp_last_q.pop_front(), "pipelined");
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_and_done();
        check_value(0, longint'(done_o), "done_o after reset");
        check_value(0, longint'(level_o != '0), "level_o nonzero after reset");
        check_value(0, longint'(recon_o != '0), "recon_o nonzero after reset");
        check_value(0, longint'(last_nz_o), "last_nz_o after reset");
        coeff_i = '0;
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        check_value(0, longint'(done_o), "done_o one cycle after start");
        next_cycle();
        check_value(1, longint'(done_o), "done_o two cycles after start");
        next_cycle();
        check_value(0, longint'(done_o), "done_o three cycles after start");
    endtask

    task automatic test_mixed_block();
        flat_t coeff;
        int    q;
        int    v;
        for (int i = 0; i < NUM_COEFF; i++) begin
            q = 4 + 2 * i;
            write_matrix(FIELD_Q, i, q);
            write_matrix(FIELD_IQ, i, (1 << QFIX) / q);
            write_matrix(FIELD_BIAS, i, (i % 2) ? 32'h8000 : 32'hC000);
            write_matrix(FIELD_ZTHRESH, i, q / 2);
            write_matrix(FIELD_SHARPEN, i, i % 3);
            v = 37 * i + 5;
            coeff[i*COEFF_W +: COEFF_W] = COEFF_W'((i % 2) ? -v : v);
        end
        run_block(coeff, "mixed");
    endtask

    task automatic test_zero_threshold();
        flat_t coeff;
        int    k;
        int    v;
        for (int i = 0; i < NUM_COEFF; i++) begin
            write_matrix(FIELD_ZTHRESH, i, 60);
            write_matrix(FIELD_SHARPEN, i, 4);
            // 56 plus 4 sits just at the threshold
            case (i % 4)
                0: v = 56;
                1: v = -56;
                2: v = 57;
                default: v = -20;
            endcase
            coeff[i*COEFF_W +: COEFF_W] = COEFF_W'(v);
        end
        run_block(coeff, "threshold");
        for (int i = 0; i < NUM_COEFF; i++) begin
            k = scan_pos(i);
            if (i % 4 != 2) begin
                check_value(0, longint'($signed(level_o[k*COEFF_W +: COEFF_W])),
                            $sformatf("level below threshold, raster %0d", i));
                check_value(0, longint'($signed(recon_o[i*COEFF_W +: COEFF_W])),
                            $sformatf("recon below threshold, raster %0d", i));
            end
        end
    endtask

    task automatic test_clamp();
        flat_t coeff;
        int    k;
        for (int i = 0; i < NUM_COEFF; i++) begin
            write_matrix(FIELD_IQ, i, 32'hFFFF);
            coeff[i*COEFF_W +: COEFF_W] = COEFF_W'((i % 2) ? -30000 : 30000);
        end
        run_block(coeff, "clamp");
        for (int i = 0; i < NUM_COEFF; i++) begin
            k = scan_pos(i);
            check_value((i % 2) ? -2047 : 2047, longint'($signed(level_o[k*COEFF_W +: COEFF_W])),
                        $sformatf("clamped level, raster %0d", i));
        end
    endtask

    task automatic test_zigzag_positions();
        flat_t coeff;
        for (int r = 0; r < NUM_COEFF; r++) begin
            coeff = '0;
            coeff[r*COEFF_W +: COEFF_W] = COEFF_W'(100);
            run_block(coeff, $sformatf("one-hot raster %0d", r));
            check_value(scan_pos(r) + 1, longint'(last_nz_o),
                        $sformatf("scan length for raster %0d", r));
        end
        run_block('0, "all zero");
        check_value(0, longint'(last_nz_o), "scan length of an all-zero block");
    endtask

    task automatic test_pipelined_random();
        flat_t                 coeff;
        flat_t                 e_lvl;
        flat_t                 e_rec;
        logic [SCAN_LEN_W-1:0] e_last;
        logic [CFG_SEL_W-1:0]  sel;
        logic [CFG_DATA_W-1:0] data;
        int                    idx;
        int                    n;
        for (int b = 0; b < NUM_RANDOM; b++) begin
            for (int i = 0; i < NUM_COEFF; i++) begin
                coeff[i*COEFF_W +: COEFF_W] = COEFF_W'($random(seed));
            end
            model_block(coeff, e_lvl, e_rec, e_last);
            exp_lvl_q.push_back(e_lvl);
            exp_rec_q.push_back(e_rec);
            exp_last_q.push_back(e_last);
            coeff_i = coeff;
            start_i = 1'b1;
            // Write lands on the start edge and misses this block
            sel = CFG_SEL_W'(($random(seed) & 32'h7fffffff) % 5);
            idx = $random(seed) & 32'hF;
            case (sel)
                FIELD_ZTHRESH: data = $random(seed) & 32'h3FF;
                FIELD_BIAS:    data = $random(seed) & 32'h1FFFF;
                default:       data = $random(seed);
            endcase
            cfg_we_i    = 1'b1;
            cfg_sel_i   = sel;
            cfg_idx_i   = CFG_IDX_W'(idx);
            cfg_wdata_i = data;
            shadow_write(sel, idx, data);
            next_cycle();
            collect_result();
        end
        start_i  = 1'b0;
        cfg_we_i = 1'b0;
        n = 0;
        while (exp_lvl_q.size() != 0 && n < 8) begin
            next_cycle();
            collect_result();
            n++;
        end
        if (exp_lvl_q.size() != 0) begin
            $display("Pipelined blocks never produced all their results");
            $display("Test FAILED");
            $fatal(1, "missing results");
        end
    endtask

    initial begin
        seed        = 25166;
        rst_n       = 1'b0;
        start_i     = 1'b0;
        coeff_i     = '0;
        cfg_we_i    = 1'b0;
        cfg_sel_i   = '0;
        cfg_idx_i   = '0;
        cfg_wdata_i = '0;
        for (int i = 0; i < NUM_COEFF; i++) begin
            m_q[i]       = 0;
            m_iq[i]      = 0;
            m_sharpen[i] = 0;
            m_bias[i]    = 0;
            m_zthresh[i] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_and_done();
        test_mixed_block();
        test_zero_threshold();
        test_clamp();
        test_zigzag_positions();
        test_pipelined_random();
        $display("Test OK");
        $finish;
    end

endmodule

/* verification/quant_block_props.sv */
`timescale 1ns/100ps

module quant_block_props (
    input logic                                               clk,
    input logic                                               rst_n,
    input logic                                               start_i,
    input logic                                               cfg_we_i,
    input logic [quant_cfg_pkg::CFG_SEL_W-1:0]                cfg_sel_i,
    input logic [quant_pkg::NUM_COEFF*quant_pkg::COEFF_W-1:0] level_o,
    input logic [quant_pkg::SCAN_LEN_W-1:0]                   last_nz_o,
    input logic                                               done_o
);
    import quant_cfg_pkg::*;

    // --------------------------------------------------
    // Pipeline timing
    // --------------------------------------------------
    done_delay: assert property (
        @(posedge clk) disable iff (!rst_n)
        done_o == $past(start_i, 2)
    ) else $error("done_o is not start_i delayed by two cycles");

    // Scan length is zero only for an all-zero block
    last_nz_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        done_o |-> ((last_nz_o == '0) == (level_o == '0))
    ) else $error("last_nz_o disagrees with level_o being all zero");

    // Only defined matrix fields are written
    legal_field: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_we_i |-> (cfg_sel_i <= FIELD_SHARPEN)
    ) else $error("cfg_sel_i holds an undefined field code during a write");

endmodule

/* source/quant_block_top.sv */
`timescale 1ns/100ps

module quant_block_top (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               start_i,
    input  logic [quant_pkg::NUM_COEFF*quant_pkg::COEFF_W-1:0] coeff_i,
    input  logic                                               cfg_we_i,
    input  logic [quant_cfg_pkg::CFG_SEL_W-1:0]                cfg_sel_i,
    input  logic [quant_cfg_pkg::CFG_IDX_W-1:0]                cfg_idx_i,
    input  logic [quant_cfg_pkg::CFG_DATA_W-1:0]               cfg_wdata_i,
    output logic [quant_pkg::NUM_COEFF*quant_pkg::COEFF_W-1:0] level_o,
    output logic [quant_pkg::NUM_COEFF*quant_pkg::COEFF_W-1:0] recon_o,
    output logic [quant_pkg::SCAN_LEN_W-1:0]                   last_nz_o,
    output logic                                               done_o
);
    import quant_pkg::*;
    import quant_cfg_pkg::*;

    coeff_t       coeff_a      [NUM_COEFF];
    coeff_t       level_raster [NUM_COEFF];
    coeff_t       recon_raster [NUM_COEFF];
    coeff_t       level_scan   [NUM_COEFF];
    quant_field_e cfg_sel;

    assign cfg_sel = quant_field_e'(cfg_sel_i);

    quant_matrix_if mat_if ();

    // --------------------------------------------------
    // Matrix registers, quantizer and zigzag
    // --------------------------------------------------
    quant_matrix_regs quant_matrix_regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel),
        .cfg_idx_i   (cfg_idx_i),
        .cfg_wdata_i (cfg_wdata_i),
        .mat         (mat_if.owner)
    );

    coeff_quantizer coeff_quantizer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .coeff_i (coeff_a),
        .mat     (mat_if.user),
        .level_o (level_raster),
        .recon_o (recon_raster),
        .done_o  (done_o)
    );

    zigzag_scan zigzag_scan_i (
        .level_i   (level_raster),
        .scan_o    (level_scan),
        .last_nz_o (last_nz_o)
    );

    // Flat vectors carry index k at bits 16k and up
    for (genvar k = 0; k < NUM_COEFF; k++) begin : g_pack
        assign coeff_a[k]                     = coeff_i[k*COEFF_W +: COEFF_W];
        assign level_o[k*COEFF_W +: COEFF_W] = level_scan[k];
        assign recon_o[k*COEFF_W +: COEFF_W] = recon_raster[k];
    end

endmodule

/* source/zigzag_scan.sv */
`timescale 1ns/100ps

module zigzag_scan (
    input  quant_pkg::coeff_t                level_i [quant_pkg::NUM_COEFF],
    output quant_pkg::coeff_t                scan_o  [quant_pkg::NUM_COEFF],
    output logic [quant_pkg::SCAN_LEN_W-1:0] last_nz_o
);
    import quant_pkg::*;

    // --------------------------------------------------
    // Raster to scan reorder
    // --------------------------------------------------
    always_comb begin
        for (int k = 0; k < NUM_COEFF; k++) begin
            scan_o[k] = level_i[ZIGZAG[k]];
        end
    end

    // --------------------------------------------------
    // Scan length up to the last nonzero level
    // --------------------------------------------------
    // Later positions overwrite earlier ones, so the highest hit wins
    always_comb begin
        last_nz_o = '0;
        for (int k = 0; k < NUM_COEFF; k++) begin
            if (level_i[ZIGZAG[k]] != '0) begin
                last_nz_o = SCAN_LEN_W'(k + 1);
            end
        end
    end

endmodule

/* source/coeff_quantizer.sv */
`timescale 1ns/100ps

module coeff_quantizer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  quant_pkg::coeff_t coeff_i [quant_pkg::NUM_COEFF],
    quant_matrix_if.user      mat,
    output quant_pkg::coeff_t level_o [quant_pkg::NUM_COEFF],
    output quant_pkg::coeff_t recon_o [quant_pkg::NUM_COEFF],
    output logic              done_o
);
    import quant_pkg::*;
    import quant_cfg_pkg::*;

    // --------------------------------------------------
    // Stage 1 arithmetic, per lane
    // --------------------------------------------------
    // Magnitude of the input coefficient
    logic [COEFF_W-1:0]              abs_c   [NUM_COEFF];
    // Magnitude plus sharpening term
    logic [COEFF_W:0]                sharp_v [NUM_COEFF];
    // Value times iq plus bias, full width
    logic [COEFF_W+STEP_W+1:0]       scaled  [NUM_COEFF];
    // Scaled value after the QFIX shift
    logic [COEFF_W+STEP_W+1-QFIX:0]  quo     [NUM_COEFF];

    always_comb begin
        for (int i = 0; i < NUM_COEFF; i++) begin
            abs_c[i]   = coeff_i[i][COEFF_W-1] ? -coeff_i[i] : coeff_i[i];
            sharp_v[i] = abs_c[i] + mat.sharpen[i];
            scaled[i]  = sharp_v[i] * mat.iq[i] + mat.bias[i];
            quo[i]     = scaled[i][COEFF_W+STEP_W+1:QFIX];
        end
    end

    // --------------------------------------------------
    // Stage 1 registers
    // --------------------------------------------------
    logic               s1_vld;
    logic               s1_sign [NUM_COEFF];
    logic               s1_nz   [NUM_COEFF];
    logic [LEVEL_W-1:0] s1_mag  [NUM_COEFF];
    logic [STEP_W-1:0]  s1_q    [NUM_COEFF];

    // Matrix is captured with the block so later writes miss it
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int i = 0; i < NUM_COEFF; i++) begin
                s1_sign[i] <= coeff_i[i][COEFF_W-1];
                s1_nz[i]   <= sharp_v[i] > mat.zthresh[i];
                s1_mag[i]  <= (quo[i] > MAX_LEVEL) ? LEVEL_W'(MAX_LEVEL)
                                                   : quo[i][LEVEL_W-1:0];
                s1_q[i]    <= mat.q[i];
            end
        end
    end

    // --------------------------------------------------
    // Stage 2 arithmetic, per lane
    // --------------------------------------------------
    // Signed level, zero below the threshold
    coeff_t                      lvl_s [NUM_COEFF];
    // Level times step before truncation
    logic signed [COEFF_W+STEP_W:0] prod  [NUM_COEFF];

    always_comb begin
        for (int i = 0; i < NUM_COEFF; i++) begin
            if (!s1_nz[i]) begin
                lvl_s[i] = '0;
            end else if (s1_sign[i]) begin
                lvl_s[i] = -coeff_t'(s1_mag[i]);
            end else begin
                lvl_s[i] = coeff_t'(s1_mag[i]);
            end
            prod[i] = lvl_s[i] * $signed({1'b0, s1_q[i]});
        end
    end

    // --------------------------------------------------
    // Stage 2 registers and start pipe
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_COEFF; i++) begin
                level_o[i] <= '0;
                recon_o[i] <= '0;
            end
        end else if (s1_vld) begin
            for (int i = 0; i < NUM_COEFF; i++) begin
                level_o[i] <= lvl_s[i];
                recon_o[i] <= prod[i][COEFF_W-1:0];
            end
        end
    end

    // done_o follows start_i by two edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            done_o <= 1'b0;
        end else begin
            s1_vld <= start_i;
            done_o <= s1_vld;
        end
    end

endmodule

/* source/quant_matrix_regs.sv */
`timescale 1ns/100ps

module quant_matrix_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cfg_we_i,
    input  quant_cfg_pkg::quant_field_e          cfg_sel_i,
    input  logic [quant_cfg_pkg::CFG_IDX_W-1:0]  cfg_idx_i,
    input  logic [quant_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
    quant_matrix_if.owner                        mat
);
    import quant_pkg::*;
    import quant_cfg_pkg::*;

    // --------------------------------------------------
    // Matrix storage
    // --------------------------------------------------
    logic [STEP_W-1:0] q_r       [NUM_COEFF];
    logic [STEP_W-1:0] iq_r      [NUM_COEFF];
    logic [STEP_W-1:0] sharpen_r [NUM_COEFF];
    logic [BIAS_W-1:0] bias_r    [NUM_COEFF];
    logic [BIAS_W-1:0] zthresh_r [NUM_COEFF];

    // Narrow fields keep the low bits of the write data
    logic [STEP_W-1:0] wdata_step;
    logic [BIAS_W-1:0] wdata_bias;

    assign wdata_step = cfg_wdata_i[STEP_W-1:0];
    assign wdata_bias = cfg_wdata_i[BIAS_W-1:0];

    // --------------------------------------------------
    // Single-entry write decode
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_COEFF; i++) begin
                q_r[i]       <= '0;
                iq_r[i]      <= '0;
                sharpen_r[i] <= '0;
                bias_r[i]    <= '0;
                zthresh_r[i] <= '0;
            end
        end else if (cfg_we_i) begin
            case (cfg_sel_i)
                FIELD_Q: begin
                    q_r[cfg_idx_i] <= wdata_step;
                end
                FIELD_IQ: begin
                    iq_r[cfg_idx_i] <= wdata_step;
                end
                FIELD_BIAS: begin
                    bias_r[cfg_idx_i] <= wdata_bias;
                end
                FIELD_ZTHRESH: begin
                    zthresh_r[cfg_idx_i] <= wdata_bias;
                end
                FIELD_SHARPEN: begin
                    sharpen_r[cfg_idx_i] <= wdata_step;
                end
                // Unknown field code leaves the matrix as it is
                default: begin
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Matrix out to the quantizer
    // --------------------------------------------------
    assign mat.q       = q_r;
    assign mat.iq      = iq_r;
    assign mat.sharpen = sharpen_r;
    assign mat.bias    = bias_r;
    assign mat.zthresh = zthresh_r;

endmodule

/* source/quant_matrix_if.sv */
`timescale 1ns/100ps

interface quant_matrix_if;
    import quant_pkg::*;
    import quant_cfg_pkg::*;

    // Quantizer step and its fixed-point inverse
    logic [STEP_W-1:0] q       [NUM_COEFF];
    logic [STEP_W-1:0] iq      [NUM_COEFF];

    // Added to the magnitude before the threshold test
    logic [STEP_W-1:0] sharpen [NUM_COEFF];

    // Rounding bias and zero threshold
    logic [BIAS_W-1:0] bias    [NUM_COEFF];
    logic [BIAS_W-1:0] zthresh [NUM_COEFF];

    // Register block side
    modport owner (
        output q, iq, sharpen, bias, zthresh
    );

    // Quantizer side
    modport user (
        input q, iq, sharpen, bias, zthresh
    );

endinterface

/* source/quant_cfg_pkg.sv */
package quant_cfg_pkg;

    // --------------------------------------------------
    // Matrix entry widths
    // --------------------------------------------------
    // q, iq and sharpen
    localparam int STEP_W = 16;
    // bias and zthresh
    localparam int BIAS_W = 32;

    // --------------------------------------------------
    // Configuration write port
    // --------------------------------------------------
    localparam int CFG_DATA_W = 32;
    localparam int CFG_IDX_W  = 4;
    localparam int CFG_SEL_W  = 3;

    // Matrix array targeted by a write
    typedef enum logic [CFG_SEL_W-1:0] {
        FIELD_Q       = 3'd0,
        FIELD_IQ      = 3'd1,
        FIELD_BIAS    = 3'd2,
        FIELD_ZTHRESH = 3'd3,
        FIELD_SHARPEN = 3'd4
    } quant_field_e;

endpackage

/* source/quant_pkg.sv */
package quant_pkg;

    // --------------------------------------------------
    // Block geometry and coefficient format
    // --------------------------------------------------
    localparam int NUM_COEFF  = 16;
    localparam int COEFF_W    = 16;

    // Scan length counts 0 to 16
    localparam int SCAN_LEN_W = 5;

    // --------------------------------------------------
    // Fixed-point quantizer constants
    // --------------------------------------------------
    localparam int QFIX      = 17;
    localparam int LEVEL_W   = 11;
    localparam int MAX_LEVEL = (1 << LEVEL_W) - 1;

    // Input coefficients, levels and reconstructed values
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // Raster index of the coefficient at each scan position
    localparam int ZIGZAG [NUM_COEFF] = '{
         0,  1,  4,  8,
         5,  2,  3,  6,
         9, 12, 13, 10,
         7, 11, 14, 15
    };

endpackage
